//--- hw/bd_io_pkg.sv
`default_nettype none

package bd_io_pkg;

    // Word widths on the two chip channels
    localparam int up_width = 21;  // Pin to core word
    localparam int dn_width = 34;  // Core to pin word

    // FIFO depths in words, powers of two
    localparam int up_depth = 8;   // Upstream burst buffer
    localparam int dn_depth = 4;   // Downstream buffer ahead of the pin register

    // Upstream adapter state from rx_v and FIFO ready
    typedef enum logic {
        rx_idle = 1'b0,            // No word or no room
        rx_take = 1'b1             // Word offered and room in the FIFO
    } rx_state_t;

    // Downstream adapter state formed as {tx_a, core_valid}
    typedef enum logic [1:0] {
        tx_both_off = 2'b00,       // No ack and nothing from the core
        tx_core_off = 2'b10,       // Ack seen but the core has nothing
        tx_pin_off  = 2'b01,       // Core word waiting and no ack
        tx_both_on  = 2'b11        // Ack and next word both present
    } tx_state_t;

endpackage : bd_io_pkg

`default_nettype wire

//--- hw/bd_pin_rx.sv
`default_nettype none

module bd_pin_rx (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [bd_io_pkg::up_width-1:0] rx_d,        // Word from the chip pins
    input  logic                           rx_v,        // Chip word valid
    output logic                           rx_a,        // Acknowledge back to the chip
    output logic [bd_io_pkg::up_width-1:0] word,        // Word toward the upstream FIFO
    output logic                           word_valid,  // Write strobe for the FIFO
    input  logic                           word_ready   // FIFO has room
);
    import bd_io_pkg::*;

    rx_state_t state;  // Decided from pins and FIFO room

    // Take a word only when the chip offers one and the FIFO can hold it
    assign state = rx_state_t'(rx_v & word_ready);

    // Falling edge on purpose
    // The chip then has half a cycle to see rx_a before it moves on at the rising edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            rx_a       <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            case (state)
                rx_idle: begin
                    rx_a       <= 1'b0;  // No ack this half cycle
                    word_valid <= 1'b0;  // Nothing for the FIFO
                end
                rx_take: begin
                    rx_a       <= 1'b1;  // Ack for the half cycle up to the rising edge
                    word_valid <= 1'b1;  // FIFO writes at that rising edge
                end
            endcase
        end
    end

    // Payload latch on the same falling edge
    always_ff @(negedge clk) begin
        if (state == rx_take) begin
            word <= rx_d;  // Held until the next accepted word
        end
    end

endmodule : bd_pin_rx

`default_nettype wire

//--- hw/bd_pin_tx.sv
`default_nettype none

module bd_pin_tx (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [bd_io_pkg::dn_width-1:0] core_data,   // Word from the downstream FIFO
    input  logic                           core_valid,  // FIFO has a word
    output logic                           core_ready,  // Pin register can load now
    output logic [bd_io_pkg::dn_width-1:0] tx_d,        // Word on the chip pins
    output logic                           tx_v,        // Pin word valid
    input  logic                           tx_a         // Chip acknowledge
);
    import bd_io_pkg::*;

    tx_state_t state;  // {ack, core valid} as in the transfer table
    logic      load;   // Pin register takes core_data this edge

    assign state = tx_state_t'({tx_a, core_valid});

    // Room when the pin register is empty or its word is acknowledged now
    // Kept combinational so a word can follow every cycle
    assign core_ready = ~tx_v | tx_a;
    assign load       = core_valid & core_ready;

    // Valid flag follows the transfer table
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_v <= 1'b0;  // Pins idle after reset
        end else begin
            case (state)
                tx_both_off: begin
                    tx_v <= tx_v;  // Keep waiting for the chip or stay idle
                end
                tx_pin_off: begin
                    tx_v <= 1'b1;  // Either holding the word or loading into an empty register
                end
                tx_core_off: begin
                    tx_v <= 1'b0;  // Word taken and no successor
                end
                tx_both_on: begin
                    tx_v <= 1'b1;  // Next word replaces the acknowledged one
                end
            endcase
        end
    end

    // Pin data changes only on a load
    // Holds steady while tx_v is high and tx_a low
    always_ff @(posedge clk) begin
        if (load) begin
            tx_d <= core_data;
        end
    end

endmodule : bd_pin_tx

`default_nettype wire

//--- hw/bd_word_fifo.sv
`default_nettype none

module bd_word_fifo #(
    parameter int width = 8,  // Word width
    parameter int depth = 4   // Entries, power of two and at least 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] wr_data,   // Write word
    input  logic             wr_valid,  // Writer has a word
    output logic             wr_ready,  // Not full
    output logic [width-1:0] rd_data,   // Head of the queue
    output logic             rd_valid,  // Not empty
    input  logic             rd_ready   // Reader takes the head
);

    logic [width-1:0]         mem [depth];  // Circular storage
    logic [$clog2(depth):0]   wr_ptr;       // Extra msb tells full from empty
    logic [$clog2(depth):0]   rd_ptr;
    logic [$clog2(depth):0]   wr_ptr_nxt;
    logic [$clog2(depth):0]   rd_ptr_nxt;
    logic                     wr_fire;      // Write handshake this edge
    logic                     rd_fire;      // Read handshake this edge
    logic                     full_nxt;     // Full after this edge

    assign wr_fire = wr_valid & wr_ready;
    assign rd_fire = rd_valid & rd_ready;

    // Pointer steps, both may move in one cycle
    assign wr_ptr_nxt = wr_ptr + {{$clog2(depth){1'b0}}, wr_fire};
    assign rd_ptr_nxt = rd_ptr + {{$clog2(depth){1'b0}}, rd_fire};

    // Full when addresses match and the wrap bits differ
    assign full_nxt = (wr_ptr_nxt[$clog2(depth)] != rd_ptr_nxt[$clog2(depth)]) &&
                      (wr_ptr_nxt[$clog2(depth)-1:0] == rd_ptr_nxt[$clog2(depth)-1:0]);

    // Empty when pointers are equal
    assign rd_valid = (wr_ptr != rd_ptr);
    assign rd_data  = mem[rd_ptr[$clog2(depth)-1:0]];  // Shows right after the write edge

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            wr_ready <= 1'b0;        // No writes accepted while in reset
        end else begin
            wr_ptr   <= wr_ptr_nxt;
            rd_ptr   <= rd_ptr_nxt;
            wr_ready <= ~full_nxt;   // Registered not-full
        end
    end

    // Storage write
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr[$clog2(depth)-1:0]] <= wr_data;
        end
    end

endmodule : bd_word_fifo

`default_nettype wire

//--- hw/bd_io_top.sv
`default_nettype none

module bd_io_top (
    input  logic                           clk,
    input  logic                           reset,
    // Upstream chip pins
    input  logic [bd_io_pkg::up_width-1:0] rx_d,
    input  logic                           rx_v,
    output logic                           rx_a,
    // Downstream chip pins
    output logic [bd_io_pkg::dn_width-1:0] tx_d,
    output logic                           tx_v,
    input  logic                           tx_a,
    // Core side, upstream words
    output logic [bd_io_pkg::up_width-1:0] up_data,
    output logic                           up_valid,
    input  logic                           up_ready,
    // Core side, downstream words
    input  logic [bd_io_pkg::dn_width-1:0] dn_data,
    input  logic                           dn_valid,
    output logic                           dn_ready
);
    import bd_io_pkg::*;

    logic [up_width-1:0] rx_word;        // Adapter to upstream FIFO
    logic                rx_word_valid;
    logic                fifo_up_ready;
    logic [dn_width-1:0] fifo_dn_data;   // Downstream FIFO to adapter
    logic                fifo_dn_valid;
    logic                tx_ready;

    // Chip to core
    bd_pin_rx rx_i (
        .clk        (clk),
        .reset      (reset),
        .rx_d       (rx_d),
        .rx_v       (rx_v),
        .rx_a       (rx_a),
        .word       (rx_word),
        .word_valid (rx_word_valid),
        .word_ready (fifo_up_ready)
    );

    bd_word_fifo #(.width(up_width), .depth(up_depth)) up_fifo_i (
        .clk      (clk),
        .reset    (reset),
        .wr_data  (rx_word),
        .wr_valid (rx_word_valid),
        .wr_ready (fifo_up_ready),
        .rd_data  (up_data),
        .rd_valid (up_valid),
        .rd_ready (up_ready)
    );

    // Core to chip
    bd_word_fifo #(.width(dn_width), .depth(dn_depth)) dn_fifo_i (
        .clk      (clk),
        .reset    (reset),
        .wr_data  (dn_data),
        .wr_valid (dn_valid),
        .wr_ready (dn_ready),
        .rd_data  (fifo_dn_data),
        .rd_valid (fifo_dn_valid),
        .rd_ready (tx_ready)
    );

    bd_pin_tx tx_i (
        .clk        (clk),
        .reset      (reset),
        .core_data  (fifo_dn_data),
        .core_valid (fifo_dn_valid),
        .core_ready (tx_ready),
        .tx_d       (tx_d),
        .tx_v       (tx_v),
        .tx_a       (tx_a)
    );

endmodule : bd_io_top

`default_nettype wire

//--- dv/bd_io_props.sv
`default_nettype none

module bd_io_props (
    input wire logic                           clk,
    input wire logic                           reset,
    input wire logic                           rx_v,
    input wire logic                           rx_a,
    input wire logic [bd_io_pkg::dn_width-1:0] tx_d,
    input wire logic                           tx_v,
    input wire logic                           tx_a,
    input wire logic [bd_io_pkg::up_width-1:0] up_data,
    input wire logic                           up_valid,
    input wire logic                           up_ready,
    input wire logic                           dn_ready
);
    import bd_io_pkg::*;

    int fail_count = 0;  // Read by the testbench at the end of the run

    // Pin word and valid hold until the chip acknowledges
    tx_hold_a: assert property (@(posedge clk) disable iff (reset)
        (tx_v && !tx_a) |=> (tx_v && $stable(tx_d)))
        else begin
            $error("tx_d or tx_v changed before tx_a");
            fail_count++;
        end

    // Ack only after a falling edge that saw a chip word
    rx_ack_a: assert property (@(negedge clk) disable iff (reset)
        rx_a |-> $past(rx_v))
        else begin
            $error("rx_a raised without rx_v at the falling edge");
            fail_count++;
        end

    // Core side upstream word holds until taken
    up_hold_a: assert property (@(posedge clk) disable iff (reset)
        (up_valid && !up_ready) |=> (up_valid && $stable(up_data)))
        else begin
            $error("up_valid or up_data changed before up_ready");
            fail_count++;
        end

    // Outputs quiet during reset
    reset_idle_a: assert property (@(posedge clk)
        reset |-> (!rx_a && !tx_v && !up_valid && !dn_ready))
        else begin
            $error("Outputs active during reset");
            fail_count++;
        end

endmodule : bd_io_props

bind bd_io_top bd_io_props props_i (.*);

`default_nettype wire

//--- dv/tb_bd_io.sv
`default_nettype none

module tb_bd_io;
    import bd_io_pkg::*;

    localparam int up_words_order = 40;
    localparam int up_words_bp    = 16;
    localparam int dn_words_order = 40;
    localparam int dn_words_bp    = 12;
    localparam int cycle_limit    = 4 * (up_words_order + up_words_bp
                                         + dn_words_order + dn_words_bp) + 200;

    logic                clk;
    logic                reset;
    logic [up_width-1:0] rx_d;
    logic                rx_v;
    logic                rx_a;
    logic [dn_width-1:0] tx_d;
    logic                tx_v;
    logic                tx_a;
    logic [up_width-1:0] up_data;
    logic                up_valid;
    logic                up_ready;
    logic [dn_width-1:0] dn_data;
    logic                dn_valid;
    logic                dn_ready;

    logic [up_width-1:0] up_q [$];  // Chip words acked, in order
    logic [dn_width-1:0] dn_q [$];  // Core words accepted, in order
    int up_left = 0;                // Chip words still to offer
    int dn_left = 0;                // Core words still to offer
    int up_ready_mode = 0;          // 0 low, 1 random
    int tx_a_mode = 0;              // 0 low, 1 random
    int up_acked = 0;
    int up_got = 0;
    int dn_accepted = 0;
    int dn_got = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;

    bd_io_top bd_io_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Scoreboards, sampled at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (rx_v && rx_a) begin
                up_q.push_back(rx_d);
                up_acked++;
            end
            if (up_valid && up_ready) begin
                up_got++;
                assert (up_q.size() > 0 && up_data == up_q[0]) else begin
                    $display("FAILED %0t: up_data %h out of order", $time, up_data);
                    errors++;
                end
                if (up_q.size() > 0) void'(up_q.pop_front());
            end
            if (dn_valid && dn_ready) begin
                dn_q.push_back(dn_data);
                dn_accepted++;
            end
            if (tx_v && tx_a) begin
                dn_got++;
                assert (dn_q.size() > 0 && tx_d == dn_q[0]) else begin
                    $display("FAILED %0t: tx_d %h out of order", $time, tx_d);
                    errors++;
                end
                if (dn_q.size() > 0) void'(dn_q.pop_front());
            end
        end
    end

    // Chip and core models
    initial begin
        int unsigned seed_val;
        logic        up_taken;
        logic        dn_taken;
        seed_val = $urandom(32'h04ef5264);  // One seed for the whole run
        forever begin
            @(posedge clk);
            up_taken = rx_v && rx_a;          // Values before this edge
            dn_taken = dn_valid && dn_ready;
            #2;
            if (!reset) begin
                if (up_taken) rx_v = 1'b0;
                if (!rx_v && up_left > 0 && ($urandom % 4) != 0) begin
                    rx_d    = up_width'($urandom);
                    rx_v    = 1'b1;
                    up_left--;
                end
                if (dn_taken) dn_valid = 1'b0;
                if (!dn_valid && dn_left > 0 && ($urandom % 4) != 0) begin
                    dn_data  = dn_width'({$urandom, $urandom});
                    dn_valid = 1'b1;
                    dn_left--;
                end
                up_ready = (up_ready_mode == 1) && (($urandom % 2) == 1);
                tx_a     = (tx_a_mode == 1) && (($urandom % 2) == 1);
            end
        end
    end

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
        end
    endtask

    task automatic check_idle_outputs();
        assert (!rx_a && !tx_v && !up_valid && !dn_ready) else begin
            $display("FAILED %0t: outputs not idle around reset", $time);
            errors++;
        end
    endtask

    initial begin
        int base;
        int err_base;
        reset    = 1'b1;
        rx_d     = '0;
        rx_v     = 1'b0;
        tx_a     = 1'b0;
        up_ready = 1'b0;
        dn_data  = '0;
        dn_valid = 1'b0;

        // Reset state
        err_base = errors;
        repeat (2) @(posedge clk);
        check_idle_outputs();
        #2 reset = 1'b0;
        @(posedge clk);
        check_idle_outputs();
        finish_test("reset state", err_base);

        // Upstream order with random back-pressure
        err_base      = errors;
        base          = up_got;
        up_ready_mode = 1;
        up_left       = up_words_order;
        while (up_got < base + up_words_order) @(posedge clk);
        finish_test("upstream order", err_base);

        // Upstream FIFO fills to depth
        err_base      = errors;
        base          = up_acked;
        up_ready_mode = 0;
        up_left       = up_words_bp;
        while (up_acked < base + up_depth) @(posedge clk);
        repeat (20) @(posedge clk);
        assert (up_acked == base + up_depth && !rx_a) else begin
            $display("FAILED %0t: %0d words acked under back-pressure",
                     $time, up_acked - base);
            errors++;
        end
        base          = up_got;
        up_ready_mode = 1;
        while (up_got < base + up_words_bp) @(posedge clk);
        finish_test("upstream back-pressure", err_base);

        // Downstream order with random acks
        err_base  = errors;
        base      = dn_got;
        tx_a_mode = 1;
        dn_left   = dn_words_order;
        while (dn_got < base + dn_words_order) @(posedge clk);
        finish_test("downstream order", err_base);

        // Downstream FIFO plus pin register fill
        err_base  = errors;
        base      = dn_accepted;
        tx_a_mode = 0;
        dn_left   = dn_words_bp;
        while (dn_accepted < base + dn_depth + 1) @(posedge clk);
        repeat (20) @(posedge clk);
        assert (dn_accepted == base + dn_depth + 1 && !dn_ready) else begin
            $display("FAILED %0t: %0d words accepted with tx_a low",
                     $time, dn_accepted - base);
            errors++;
        end
        base      = dn_got;
        tx_a_mode = 1;
        while (dn_got < base + dn_words_bp) @(posedge clk);
        finish_test("downstream back-pressure", err_base);

        repeat (5) @(posedge clk);
        $display("Tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, bd_io_top_i.props_i.fail_count);
        if (errors == 0 && bd_io_top_i.props_i.fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_bd_io

`default_nettype wire

//--- files.f
hw/bd_io_pkg.sv
hw/bd_pin_rx.sv
hw/bd_pin_tx.sv
hw/bd_word_fifo.sv
hw/bd_io_top.sv
dv/bd_io_props.sv
dv/tb_bd_io.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bd_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f files.f \
    --top-module tb_bd_io \
    --Mdir obj_dir \
    -o tb_bd_io
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_bd_io +verilator+error+limit+100 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation run returned status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    echo "Pass message not found in sim.log"
    exit 1
fi
